/* common/uart_pkg.sv */
// shared types and constants of the 8N1 UART register block
// fixed frame format, parity and word length bits in LCR are storage only
`default_nettype none

package uart_pkg;

  //////////////////////////////////////////////////////////////////////
  // widths and types
  //////////////////////////////////////////////////////////////////////
  typedef logic [7:0]  uart_byte_t;   // data byte or register value
  typedef logic [15:0] uart_div_t;    // divisor latch
  typedef logic [2:0]  uart_addr_t;   // register offset

  // register offsets, 0 and 1 map to the divisor latch while DLAB is set
  typedef enum uart_addr_t {
    RB_TR = 3'd0,  // rbr read, thr write, dl low with dlab
    IE    = 3'd1,  // ier, dl high with dlab
    II_FC = 3'd2,  // iir read, fcr write ignored
    LC    = 3'd3,
    MC    = 3'd4,
    LS    = 3'd5,
    MS    = 3'd6,  // no modem status, reads 0
    SR    = 3'd7
  } uart_reg_e;

  // iir bits 3:1
  typedef enum logic [2:0] {
    NONE = 3'd0,
    THRE = 3'd1,
    RDA  = 3'd2,
    RLS  = 3'd3
  } uart_iir_id_e;

  //////////////////////////////////////////////////////////////////////
  // bit positions
  //////////////////////////////////////////////////////////////////////
  localparam int LC_DLAB = 7;
  localparam int MC_DTR  = 0;
  localparam int MC_RTS  = 1;
  localparam int MC_LOOP = 4;
  localparam int IE_RDA  = 0;
  localparam int IE_THRE = 1;
  localparam int IE_RLS  = 2;
  localparam int LS_DR   = 0;
  localparam int LS_OE   = 1;
  localparam int LS_FE   = 3;
  localparam int LS_THRE = 5;
  localparam int LS_TEMT = 6;

  // frame timing
  localparam int OVERSAMPLE   = 16;  // ticks per bit
  localparam int SAMPLE_POINT = 8;   // mid bit
  localparam int DATA_BITS    = 8;

  localparam uart_byte_t LCR_RESET = 8'h03;  // 8n1

  typedef logic [$clog2(OVERSAMPLE)-1:0] tick_cnt_t;  // tick within a bit
  typedef logic [$clog2(DATA_BITS)-1:0]  bit_cnt_t;   // data bit index

  localparam tick_cnt_t LAST_TICK   = tick_cnt_t'(OVERSAMPLE - 1);
  localparam tick_cnt_t SAMPLE_TICK = tick_cnt_t'(SAMPLE_POINT - 1);
  localparam bit_cnt_t  LAST_BIT    = bit_cnt_t'(DATA_BITS - 1);

  // both serial fsms walk through the same frame phases
  typedef enum logic [1:0] {
    IDLE,
    START,
    DATA,
    STOP
  } frame_state_e;

  //////////////////////////////////////////////////////////////////////
  // stage payloads
  //////////////////////////////////////////////////////////////////////
  typedef struct packed {
    uart_byte_t data;
    logic       framing_err;  // stop bit read 0
    logic       valid;        // one cycle, at stop sample
  } rx_frame_t;

  typedef struct packed {
    logic thr_empty;
    logic shifter_idle;
  } tx_status_t;

  typedef struct packed {
    uart_byte_t data;
    logic       push;  // thr write strobe
  } tx_load_t;

endpackage

`default_nettype wire

/* rx/uart_rx.sv */
// 8N1 deserializer, mid-bit sampling on the 16x tick
// a new start needs the line to have been seen high while idle
`default_nettype none

module uart_rx (
  input  wire                    clk,
  input  wire                    wb_rst_i,
  input  wire                    tick_i,
  input  wire                    serial_i,
  output uart_pkg::rx_frame_t    frame_o
);

  import uart_pkg::*;

  logic         rx_meta_q;    // first sync stage
  logic         rx_s_q;       // synchronized line
  frame_state_e state_q;
  tick_cnt_t    tick_cnt_q;
  bit_cnt_t     bit_cnt_q;
  uart_byte_t   shift_q;
  logic         armed_q;      // line was high since last frame
  logic         valid_q;
  logic         fe_q;
  logic         sample_start; // middle of start bit
  logic         sample_bit;   // middle of data or stop bit

  //////////////////////////////////////////////////////////////////////
  // input synchronizer, idles at mark
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk or posedge wb_rst_i) begin
    if (wb_rst_i) begin
      rx_meta_q <= 1'b1;
      rx_s_q    <= 1'b1;
    end else begin
      rx_meta_q <= serial_i;
      rx_s_q    <= rx_meta_q;
    end
  end

  assign sample_start = tick_i && (tick_cnt_q == SAMPLE_TICK);
  assign sample_bit   = tick_i && (tick_cnt_q == LAST_TICK);

  // data and error flag are payload, no reset
  always_ff @(posedge clk) begin
    if ((state_q == DATA) && sample_bit) shift_q <= {rx_s_q, shift_q[7:1]};
    if ((state_q == STOP) && sample_bit) fe_q <= ~rx_s_q;  // stop read 0
  end

  //////////////////////////////////////////////////////////////////////
  // frame fsm
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk or posedge wb_rst_i) begin
    if (wb_rst_i) begin
      state_q    <= IDLE;
      tick_cnt_q <= '0;
      bit_cnt_q  <= '0;
      armed_q    <= 1'b0;
      valid_q    <= 1'b0;
    end else begin
      valid_q <= 1'b0;
      if (tick_i) tick_cnt_q <= tick_cnt_q + 1'b1;
      case (state_q)
        IDLE: begin
          if (rx_s_q) begin
            armed_q <= 1'b1;
          end else if (tick_i && armed_q) begin
            state_q    <= START;   // low at a tick, frame begins
            tick_cnt_q <= '0;
            bit_cnt_q  <= '0;
            armed_q    <= 1'b0;
          end
        end
        START: begin
          if (sample_start) begin
            tick_cnt_q <= '0;      // realign to mid bit
            state_q    <= rx_s_q ? IDLE : DATA;  // high means glitch
          end
        end
        DATA: begin
          if (sample_bit) begin
            bit_cnt_q <= bit_cnt_q + 1'b1;
            if (bit_cnt_q == LAST_BIT) state_q <= STOP;
          end
        end
        STOP: begin
          if (sample_bit) begin
            valid_q <= 1'b1;
            state_q <= IDLE;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  assign frame_o = '{data: shift_q, framing_err: fe_q, valid: valid_q};

endmodule

`default_nettype wire

/* source/uart_baud_gen.sv */
// 16x oversampling tick, one pulse every divisor clocks
// divisor 0 stops the tick, a DL low write restarts the count
`default_nettype none

module uart_baud_gen (
  input  wire                      clk,
  input  wire                      wb_rst_i,
  input  wire uart_pkg::uart_div_t divisor_i,
  input  wire                      dl_write_i,
  output logic                     tick_o
);

  import uart_pkg::*;

  uart_div_t cnt_q;   // down counter
  logic      tick_q;

  always_ff @(posedge clk or posedge wb_rst_i) begin
    if (wb_rst_i) begin
      cnt_q  <= '0;
      tick_q <= 1'b0;
    end else begin
      tick_q <= (divisor_i != '0) && (cnt_q == '0);
      if (dl_write_i || (cnt_q == '0)) begin
        cnt_q <= divisor_i - 1'b1;   // reload, wraps harmlessly when 0
      end else begin
        cnt_q <= cnt_q - 1'b1;
      end
    end
  end

  assign tick_o = tick_q;

endmodule

`default_nettype wire

/* source/uart_core.sv */
// UART top level, single holding byte per direction, no FIFOs, no modem inputs
// MCR bit 4 loops tx back into rx and parks stx_pad_o high
`default_nettype none

module uart_core (
  input  wire                       clk,
  input  wire                       wb_rst_i,
  input  wire uart_pkg::uart_addr_t wb_addr_i,
  input  wire uart_pkg::uart_byte_t wb_dat_i,
  output wire uart_pkg::uart_byte_t wb_dat_o,
  input  wire                       wb_we_i,
  input  wire                       wb_re_i,
  input  wire                       srx_pad_i,
  output wire                       stx_pad_o,
  output wire                       rts_pad_o,
  output wire                       dtr_pad_o,
  output wire                       int_o
);

  import uart_pkg::*;

  uart_div_t  divisor;    // dl latch to divider
  logic       dl_write;   // restart divider
  logic       tick;       // 16x baud
  tx_load_t   tx_load;
  tx_status_t tx_status;
  rx_frame_t  rx_frame;
  uart_byte_t mcr;
  logic       loop;
  logic       tx_serial;  // raw transmitter output
  logic       rx_serial;  // receiver input after loopback mux

  //////////////////////////////////////////////////////////////////////
  // loopback and modem outputs
  //////////////////////////////////////////////////////////////////////
  assign loop      = mcr[MC_LOOP];
  assign rx_serial = loop ? tx_serial : srx_pad_i;
  assign stx_pad_o = loop ? 1'b1 : tx_serial;  // line stays marking
  assign rts_pad_o = mcr[MC_RTS];
  assign dtr_pad_o = mcr[MC_DTR];

  uart_regs u_regs (
    .clk        (clk),
    .wb_rst_i   (wb_rst_i),
    .wb_addr_i  (wb_addr_i),
    .wb_dat_i   (wb_dat_i),
    .wb_dat_o   (wb_dat_o),
    .wb_we_i    (wb_we_i),
    .wb_re_i    (wb_re_i),
    .divisor_o  (divisor),
    .dl_write_o (dl_write),
    .tx_load_o  (tx_load),
    .tx_status_i(tx_status),
    .rx_frame_i (rx_frame),
    .mcr_o      (mcr),
    .int_o      (int_o)
  );

  uart_baud_gen u_baud (
    .clk       (clk),
    .wb_rst_i  (wb_rst_i),
    .divisor_i (divisor),
    .dl_write_i(dl_write),
    .tick_o    (tick)
  );

  uart_tx u_tx (
    .clk     (clk),
    .wb_rst_i(wb_rst_i),
    .tick_i  (tick),
    .load_i  (tx_load),
    .status_o(tx_status),
    .serial_o(tx_serial)
  );

  uart_rx u_rx (
    .clk     (clk),
    .wb_rst_i(wb_rst_i),
    .tick_i  (tick),
    .serial_i(rx_serial),
    .frame_o (rx_frame)
  );

endmodule

`default_nettype wire

/* source/uart_regs.sv */
// register file of the UART, strobes are single cycle, reads are combinational
// FCR writes ignored, MSR reads 0, PE and BI read 0, interrupts are plain levels
`default_nettype none

module uart_regs (
  input  wire                         clk,
  input  wire                         wb_rst_i,
  input  wire uart_pkg::uart_addr_t   wb_addr_i,
  input  wire uart_pkg::uart_byte_t   wb_dat_i,
  output uart_pkg::uart_byte_t        wb_dat_o,
  input  wire                         wb_we_i,
  input  wire                         wb_re_i,
  output uart_pkg::uart_div_t         divisor_o,
  output logic                        dl_write_o,
  output uart_pkg::tx_load_t          tx_load_o,
  input  wire uart_pkg::tx_status_t   tx_status_i,
  input  wire uart_pkg::rx_frame_t    rx_frame_i,
  output uart_pkg::uart_byte_t        mcr_o,
  output logic                        int_o
);

  import uart_pkg::*;

  logic         dlab;
  logic         wr_rb, wr_ie;      // raw offset hits
  logic         wr_dll, wr_dlm, wr_thr, wr_ier;
  logic         rd_rbr, rd_lsr;    // reads with side effects
  uart_div_t    dl_q;
  logic [3:0]   ier_q;             // bit 3 stored only
  uart_byte_t   lcr_q;
  logic [4:0]   mcr_q;
  uart_byte_t   scr_q;
  uart_byte_t   rbr_q;
  logic         dr_q, oe_q, fe_q;  // sticky line status
  logic         dl_write_q;
  uart_byte_t   lsr;
  logic         rls_int, rda_int, thre_int;
  uart_iir_id_e iir_id_q;

  //////////////////////////////////////////////////////////////////////
  // access decode
  //////////////////////////////////////////////////////////////////////
  assign dlab   = lcr_q[LC_DLAB];
  assign wr_rb  = wb_we_i && (wb_addr_i == RB_TR);
  assign wr_ie  = wb_we_i && (wb_addr_i == IE);
  assign wr_dll = wr_rb && dlab;
  assign wr_thr = wr_rb && !dlab;
  assign wr_dlm = wr_ie && dlab;
  assign wr_ier = wr_ie && !dlab;
  assign rd_rbr = wb_re_i && (wb_addr_i == RB_TR) && !dlab;
  assign rd_lsr = wb_re_i && (wb_addr_i == LS);

  // control registers
  always_ff @(posedge clk or posedge wb_rst_i) begin
    if (wb_rst_i) begin
      dl_q       <= '0;         // divider stopped
      ier_q      <= '0;
      lcr_q      <= LCR_RESET;
      mcr_q      <= '0;
      dl_write_q <= 1'b0;
    end else begin
      dl_write_q <= wr_dll;     // one cycle later, new dl already in place
      if (wr_dll) dl_q[7:0] <= wb_dat_i;
      if (wr_dlm) dl_q[15:8] <= wb_dat_i;
      if (wr_ier) ier_q <= wb_dat_i[3:0];
      if (wb_we_i && (wb_addr_i == LC)) lcr_q <= wb_dat_i;
      if (wb_we_i && (wb_addr_i == MC)) mcr_q <= wb_dat_i[4:0];
    end
  end

  always_ff @(posedge clk) begin
    if (wb_we_i && (wb_addr_i == SR)) scr_q <= wb_dat_i;
    if (rx_frame_i.valid) rbr_q <= rx_frame_i.data;  // newest byte wins
  end

  //////////////////////////////////////////////////////////////////////
  // line status
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk or posedge wb_rst_i) begin
    if (wb_rst_i) begin
      dr_q <= 1'b0;
      oe_q <= 1'b0;
      fe_q <= 1'b0;
    end else begin
      if (rx_frame_i.valid) begin
        dr_q <= 1'b1;            // arrival beats a same-cycle read
      end else if (rd_rbr) begin
        dr_q <= 1'b0;
      end
      // overrun only if the old byte is not being read right now
      oe_q <= (oe_q & ~rd_lsr) | (rx_frame_i.valid & dr_q & ~rd_rbr);
      fe_q <= (fe_q & ~rd_lsr) | (rx_frame_i.valid & rx_frame_i.framing_err);
    end
  end

  always_comb begin
    lsr          = '0;           // pe, bi, fifo err stay 0
    lsr[LS_DR]   = dr_q;
    lsr[LS_OE]   = oe_q;
    lsr[LS_FE]   = fe_q;
    lsr[LS_THRE] = tx_status_i.thr_empty;
    lsr[LS_TEMT] = tx_status_i.thr_empty & tx_status_i.shifter_idle;
  end

  // enabled conditions
  assign rls_int  = ier_q[IE_RLS] & (oe_q | fe_q);
  assign rda_int  = ier_q[IE_RDA] & dr_q;
  assign thre_int = ier_q[IE_THRE] & lsr[LS_THRE];

  // iir and int_o trail the status by one clock
  always_ff @(posedge clk or posedge wb_rst_i) begin
    if (wb_rst_i) begin
      iir_id_q <= NONE;
      int_o    <= 1'b0;
    end else begin
      int_o <= rls_int | rda_int | thre_int;
      if (rls_int) begin
        iir_id_q <= RLS;         // highest
      end else if (rda_int) begin
        iir_id_q <= RDA;
      end else if (thre_int) begin
        iir_id_q <= THRE;
      end else begin
        iir_id_q <= NONE;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // read mux
  //////////////////////////////////////////////////////////////////////
  always_comb begin
    wb_dat_o = '0;
    case (wb_addr_i)
      RB_TR:   wb_dat_o = dlab ? dl_q[7:0] : rbr_q;
      IE:      wb_dat_o = dlab ? dl_q[15:8] : {4'b0000, ier_q};
      II_FC:   wb_dat_o = {4'b1100, iir_id_q, iir_id_q == NONE};  // bit 0 = none pending
      LC:      wb_dat_o = lcr_q;
      MC:      wb_dat_o = {3'b000, mcr_q};
      LS:      wb_dat_o = lsr;
      MS:      wb_dat_o = '0;
      SR:      wb_dat_o = scr_q;
      default: wb_dat_o = '0;
    endcase
  end

  assign divisor_o  = dl_q;
  assign dl_write_o = dl_write_q;
  assign tx_load_o  = '{data: wb_dat_i, push: wr_thr};  // same edge as the write
  assign mcr_o      = {3'b000, mcr_q};

endmodule

`default_nettype wire

/* tx/uart_tx.sv */
// 8N1 serializer with a single holding byte, no back-pressure
// a push into a full THR overwrites the byte
`default_nettype none

module uart_tx (
  input  wire                     clk,
  input  wire                     wb_rst_i,
  input  wire                     tick_i,
  input  wire uart_pkg::tx_load_t load_i,
  output uart_pkg::tx_status_t    status_o,
  output logic                    serial_o
);

  import uart_pkg::*;

  frame_state_e state_q;
  uart_byte_t   thr_q;        // holding byte
  logic         thr_full_q;
  uart_byte_t   shift_q;
  tick_cnt_t    tick_cnt_q;   // tick inside current bit
  bit_cnt_t     bit_cnt_q;
  logic         bit_end;      // last tick of a bit
  logic         load_shift;   // thr to shifter

  assign bit_end    = tick_i && (tick_cnt_q == LAST_TICK);
  assign load_shift = tick_i && thr_full_q && (state_q == IDLE);

  always_ff @(posedge clk) begin
    if (load_i.push) thr_q <= load_i.data;
    if (load_shift) begin
      shift_q <= thr_q;
    end else if ((state_q == DATA) && bit_end) begin
      shift_q <= shift_q >> 1;   // lsb first
    end
  end

  always_ff @(posedge clk or posedge wb_rst_i) begin
    if (wb_rst_i) begin
      thr_full_q <= 1'b0;
      state_q    <= IDLE;
      tick_cnt_q <= '0;
      bit_cnt_q  <= '0;
    end else begin
      if (load_i.push) begin
        thr_full_q <= 1'b1;
      end else if (load_shift) begin
        thr_full_q <= 1'b0;
      end
      if (tick_i) tick_cnt_q <= tick_cnt_q + 1'b1;  // wraps once per bit
      case (state_q)
        IDLE: begin
          if (load_shift) begin
            state_q    <= START;   // start bit begins here
            tick_cnt_q <= '0;
            bit_cnt_q  <= '0;
          end
        end
        START: if (bit_end) state_q <= DATA;
        DATA: begin
          if (bit_end) begin
            bit_cnt_q <= bit_cnt_q + 1'b1;
            if (bit_cnt_q == LAST_BIT) state_q <= STOP;
          end
        end
        STOP: if (bit_end) state_q <= IDLE;
        default: state_q <= IDLE;
      endcase
    end
  end

  always_comb begin
    case (state_q)
      START:   serial_o = 1'b0;
      DATA:    serial_o = shift_q[0];
      default: serial_o = 1'b1;  // idle and stop are marking
    endcase
  end

  assign status_o = '{thr_empty: ~thr_full_q, shifter_idle: state_q == IDLE};

endmodule

`default_nettype wire

/* uart_core.f */
common/uart_pkg.sv
source/uart_baud_gen.sv
tx/uart_tx.sv
rx/uart_rx.sv
source/uart_regs.sv
source/uart_core.sv
verification/uart_core_chk.sv
verification/uart_core_tb.sv

/* verification/uart_core_chk.sv */
// assertions bound into uart_core, all sampled on the rising clock edge
// valid and RB read overlap is legal in the RTL but the testbench never causes it
`default_nettype none

module uart_core_chk (
  input wire                       clk,
  input wire                       wb_rst_i,
  input wire                       tick_i,
  input wire                       stx_pad_i,
  input wire                       we_i,
  input wire uart_pkg::uart_addr_t addr_i,
  input wire uart_pkg::uart_byte_t dat_i,
  input wire [3:0]                 ier_i,
  input wire                       int_i,
  input wire                       rx_valid_i,
  input wire                       rd_rbr_i
);

  timeunit 1ns;
  timeprecision 1ps;

  import uart_pkg::*;

  int   fail_count = 0;  // failed assertions so far
  logic loop_q;          // loop bit as last written over the bus

  always_ff @(posedge clk or posedge wb_rst_i) begin
    if (wb_rst_i) begin
      loop_q <= 1'b0;
    end else if (we_i && (addr_i == MC)) begin
      loop_q <= dat_i[MC_LOOP];
    end
  end

  // divisor never 1 here, so ticks are isolated pulses
  tick_single: assert property (@(posedge clk) disable iff (wb_rst_i) tick_i |=> !tick_i)
    else begin
      $error("baud tick high on two consecutive cycles");
      fail_count++;
    end

  loop_marking: assert property (@(posedge clk) disable iff (wb_rst_i)
    loop_q |-> stx_pad_i)
    else begin
      $error("stx_pad_o left marking while loopback is on");
      fail_count++;
    end

  // int_o trails IER by one clock
  int_masked: assert property (@(posedge clk) disable iff (wb_rst_i)
    ($past(ier_i) == 4'h0) |-> !int_i)
    else begin
      $error("int_o high with all interrupts disabled");
      fail_count++;
    end

  no_read_race: assert property (@(posedge clk) disable iff (wb_rst_i)
    !(rx_valid_i && rd_rbr_i))
    else begin
      $error("receiver valid and RB read in the same cycle");
      fail_count++;
    end

endmodule

bind uart_core uart_core_chk u_chk (
  .clk       (clk),
  .wb_rst_i  (wb_rst_i),
  .tick_i    (tick),
  .stx_pad_i (stx_pad_o),
  .we_i      (wb_we_i),
  .addr_i    (wb_addr_i),
  .dat_i     (wb_dat_i),
  .ier_i     (u_regs.ier_q),
  .int_i     (int_o),
  .rx_valid_i(rx_frame.valid),
  .rd_rbr_i  (u_regs.rd_rbr)
);

`default_nettype wire

/* verification/uart_core_tb.sv */
// testbench of uart_core, divisor 2 gives 32 clocks per bit on both serial paths
// srx_pad_i frames are bit-banged here, reads sample wb_dat_o a quarter clock after setup
`default_nettype none

module uart_core_tb;

  timeunit 1ns;
  timeprecision 1ps;

  import uart_pkg::*;

  localparam int CLK_PERIOD  = 100;
  localparam int BIT_CLKS    = 32;                 // 2 clocks per tick, 16 ticks
  localparam int NUM_FRAMES  = 16;                 // 8 + 2 + 2 + 3 + 1
  localparam int FRAME_NS    = 10 * BIT_CLKS * CLK_PERIOD;
  localparam int WATCHDOG_NS = NUM_FRAMES * FRAME_NS * 3 / 2;
  localparam int POLL_LIMIT  = 2 * 10 * BIT_CLKS;  // cycles, two frames worth

  logic       clk;
  logic       wb_rst_i;
  uart_addr_t wb_addr_i;
  uart_byte_t wb_dat_i;
  uart_byte_t wb_dat_o;
  logic       wb_we_i;
  logic       wb_re_i;
  logic       srx_pad_i;
  logic       stx_pad_o;
  logic       rts_pad_o;
  logic       dtr_pad_o;
  logic       int_o;
  integer     seed;

  uart_core uut (
    .clk      (clk),
    .wb_rst_i (wb_rst_i),
    .wb_addr_i(wb_addr_i),
    .wb_dat_i (wb_dat_i),
    .wb_dat_o (wb_dat_o),
    .wb_we_i  (wb_we_i),
    .wb_re_i  (wb_re_i),
    .srx_pad_i(srx_pad_i),
    .stx_pad_o(stx_pad_o),
    .rts_pad_o(rts_pad_o),
    .dtr_pad_o(dtr_pad_o),
    .int_o    (int_o)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("ERROR: run timed out after %0d ns", WATCHDOG_NS);
    abort_run();
  end

  initial begin
    wait (uut.u_chk.fail_count != 0);
    $display("ERROR: a bound assertion failed, see the message above");
    abort_run();
  end

  ////////////////////////////////////////////////////////////////////
  // reference model and compares
  ////////////////////////////////////////////////////////////////////
  // thr is always empty when software looks, nothing is queued then
  function automatic uart_byte_t expected_lsr(input logic unread, input logic overrun,
                                              input logic stop_zero, input logic tx_idle);
    uart_byte_t v;
    v          = 8'h00;
    v[LS_DR]   = unread;
    v[LS_OE]   = overrun;
    v[LS_FE]   = stop_zero;
    v[LS_THRE] = 1'b1;
    v[LS_TEMT] = tx_idle;  // shifter done too
    return v;
  endfunction

  task automatic abort_run();
    $display("** FAIL **");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_byte(input string name, input uart_byte_t exp, input uart_byte_t act);
    if (act !== exp) begin
      $display("FAILED %s: expected %h, actual %h", name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_lsr(input string name, input uart_byte_t exp, input uart_byte_t act);
    if (act !== exp) begin
      $display("FAILED %s: expected lsr %h, actual %h", name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_iir(input string name, input uart_iir_id_e exp_id,
                           input logic exp_none, input uart_byte_t act);
    uart_byte_t exp;
    exp = {4'b1100, exp_id, exp_none};  // bit 0 high = nothing pending
    if (act !== exp) begin
      $display("FAILED %s: expected iir %h, actual %h", name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_level(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("FAILED %s: expected %b, actual %b", name, exp, act);
      abort_run();
    end
  endtask

  ////////////////////////////////////////////////////////////////////
  // bus and line drivers
  ////////////////////////////////////////////////////////////////////
  task automatic write_reg(input uart_addr_t addr, input uart_byte_t data);
    @(negedge clk);
    wb_addr_i = addr;
    wb_dat_i  = data;
    wb_we_i   = 1'b1;   // one cycle strobe
    @(negedge clk);
    wb_we_i   = 1'b0;
  endtask

  task automatic read_reg(input uart_addr_t addr, output uart_byte_t data);
    @(negedge clk);
    wb_addr_i = addr;
    wb_re_i   = 1'b1;
    #(CLK_PERIOD / 4);
    data = wb_dat_o;    // before the edge that applies side effects
    @(negedge clk);
    wb_re_i   = 1'b0;
  endtask

  // looks at LSR without the read strobe, so OE and FE survive
  task automatic wait_lsr_bit(input int bit_idx, input string what);
    int cycles;
    cycles = 0;
    @(negedge clk);
    wb_addr_i = LS;
    #(CLK_PERIOD / 4);
    while (!wb_dat_o[bit_idx]) begin
      if (cycles == POLL_LIMIT) begin
        $display("ERROR: %s, LSR bit %0d never came up", what, bit_idx);
        abort_run();
      end
      cycles++;
      @(negedge clk);
      #(CLK_PERIOD / 4);
    end
  endtask

  task automatic send_frame(input uart_byte_t data, input logic stop_bit);
    @(negedge clk);
    srx_pad_i = 1'b0;   // start
    repeat (BIT_CLKS) @(negedge clk);
    for (int n = 0; n < DATA_BITS; n++) begin
      srx_pad_i = data[n];  // lsb first
      repeat (BIT_CLKS) @(negedge clk);
    end
    srx_pad_i = stop_bit;
    repeat (BIT_CLKS) @(negedge clk);
    srx_pad_i = 1'b1;   // back to mark
  endtask

  ////////////////////////////////////////////////////////////////////
  // tests
  ////////////////////////////////////////////////////////////////////
  task automatic test_reset_readback();
    uart_byte_t v;
    uart_byte_t val;
    check_level("int_o reset", 1'b0, int_o);
    check_level("rts reset", 1'b0, rts_pad_o);
    check_level("dtr reset", 1'b0, dtr_pad_o);
    check_level("stx reset", 1'b1, stx_pad_o);
    read_reg(LC, v);
    check_byte("lcr reset", 8'h03, v);
    read_reg(LS, v);
    check_lsr("lsr reset", expected_lsr(1'b0, 1'b0, 1'b0, 1'b1), v);
    read_reg(II_FC, v);
    check_iir("iir reset", NONE, 1'b1, v);
    val = uart_byte_t'($random(seed));
    write_reg(SR, val);
    read_reg(SR, v);
    check_byte("scr readback", val, v);
    write_reg(LC, 8'h83);     // dlab on
    write_reg(IE, 8'hA5);
    read_reg(IE, v);
    check_byte("dl high readback", 8'hA5, v);
    write_reg(IE, 8'h00);
    write_reg(RB_TR, 8'h02);  // divisor 2, divider restarts
    read_reg(RB_TR, v);
    check_byte("dl low readback", 8'h02, v);
    read_reg(IE, v);
    check_byte("dl high cleared", 8'h00, v);
    write_reg(LC, 8'h03);
    write_reg(IE, 8'hFA);
    read_reg(IE, v);
    check_byte("ier readback", 8'h0A, v);  // 4 bit register
    write_reg(IE, 8'h00);
    write_reg(MC, 8'h01);     // dtr only
    check_level("dtr set", 1'b1, dtr_pad_o);
    check_level("rts clear", 1'b0, rts_pad_o);
    write_reg(MC, 8'h02);     // rts only
    check_level("dtr clear", 1'b0, dtr_pad_o);
    check_level("rts set", 1'b1, rts_pad_o);
    write_reg(MC, 8'h00);
  endtask

  task automatic test_loopback();
    uart_byte_t data;
    uart_byte_t v;
    write_reg(MC, 8'h10);
    for (int n = 0; n < 8; n++) begin
      data = uart_byte_t'($random(seed));
      write_reg(RB_TR, data);
      wait_lsr_bit(LS_DR, "loopback receive");
      read_reg(LS, v);   // tx still in its stop bit
      check_lsr("loopback lsr before read", expected_lsr(1'b1, 1'b0, 1'b0, 1'b0), v);
      read_reg(RB_TR, v);
      check_byte("loopback data", data, v);
      check_level("loopback stx", 1'b1, stx_pad_o);
      repeat (BIT_CLKS) @(negedge clk);
      read_reg(LS, v);
      check_lsr("loopback lsr after read", expected_lsr(1'b0, 1'b0, 1'b0, 1'b1), v);
    end
    write_reg(MC, 8'h00);
  endtask

  task automatic test_external_rx();
    uart_byte_t data;
    uart_byte_t v;
    data = uart_byte_t'($random(seed));
    send_frame(data, 1'b1);
    wait_lsr_bit(LS_DR, "good frame");
    read_reg(LS, v);
    check_lsr("good frame lsr", expected_lsr(1'b1, 1'b0, 1'b0, 1'b1), v);
    read_reg(RB_TR, v);
    check_byte("good frame data", data, v);
    data = uart_byte_t'($random(seed));
    send_frame(data, 1'b0);  // broken stop bit
    wait_lsr_bit(LS_DR, "framing error frame");
    read_reg(LS, v);
    check_lsr("framing error lsr", expected_lsr(1'b1, 1'b0, 1'b1, 1'b1), v);
    read_reg(LS, v);
    check_lsr("fe cleared by lsr read", expected_lsr(1'b1, 1'b0, 1'b0, 1'b1), v);
    read_reg(RB_TR, v);
    check_byte("framing error data", data, v);
  endtask

  task automatic test_overrun();
    uart_byte_t first;
    uart_byte_t second;
    uart_byte_t v;
    first  = uart_byte_t'($random(seed));
    second = uart_byte_t'($random(seed));
    send_frame(first, 1'b1);
    wait_lsr_bit(LS_DR, "overrun first frame");
    send_frame(second, 1'b1);
    wait_lsr_bit(LS_OE, "overrun second frame");
    read_reg(LS, v);
    check_lsr("overrun lsr", expected_lsr(1'b1, 1'b1, 1'b0, 1'b1), v);
    read_reg(RB_TR, v);
    check_byte("overrun keeps newest", second, v);
    read_reg(LS, v);
    check_lsr("overrun cleared", expected_lsr(1'b0, 1'b0, 1'b0, 1'b1), v);
  endtask

  task automatic test_interrupts();
    uart_byte_t data;
    uart_byte_t v;
    write_reg(IE, 8'h03);    // rda and thre
    data = uart_byte_t'($random(seed));
    send_frame(data, 1'b1);
    wait_lsr_bit(LS_DR, "rda frame");
    read_reg(II_FC, v);
    check_iir("iir rda over thre", RDA, 1'b0, v);
    check_level("int_o with rda", 1'b1, int_o);
    read_reg(RB_TR, v);
    check_byte("rda data", data, v);
    read_reg(II_FC, v);
    check_iir("iir thre after read", THRE, 1'b0, v);
    write_reg(IE, 8'h07);    // add rls
    send_frame(uart_byte_t'($random(seed)), 1'b1);
    wait_lsr_bit(LS_DR, "rls first frame");
    data = uart_byte_t'($random(seed));
    send_frame(data, 1'b1);
    wait_lsr_bit(LS_OE, "rls second frame");
    read_reg(II_FC, v);
    check_iir("iir rls on overrun", RLS, 1'b0, v);
    read_reg(LS, v);
    check_lsr("rls lsr", expected_lsr(1'b1, 1'b1, 1'b0, 1'b1), v);
    read_reg(RB_TR, v);
    check_byte("rls data", data, v);
    write_reg(IE, 8'h00);
    read_reg(II_FC, v);
    check_iir("iir with ier 0", NONE, 1'b1, v);
    check_level("int_o with ier 0", 1'b0, int_o);
  endtask

  task automatic test_tx_serial();
    uart_byte_t data;
    uart_byte_t seen;
    uart_byte_t v;
    int         cycles;
    data   = uart_byte_t'($random(seed));
    cycles = 0;
    write_reg(RB_TR, data);
    @(negedge clk);
    while (stx_pad_o) begin   // falling start edge
      if (cycles == POLL_LIMIT) begin
        $display("ERROR: no start bit seen on stx_pad_o");
        abort_run();
      end
      cycles++;
      @(negedge clk);
    end
    repeat (BIT_CLKS / 2 - 1) @(negedge clk);  // middle of start bit
    check_level("tx start bit", 1'b0, stx_pad_o);
    for (int n = 0; n < DATA_BITS; n++) begin
      repeat (BIT_CLKS) @(negedge clk);
      seen[n] = stx_pad_o;
    end
    check_byte("tx serial data", data, seen);
    repeat (BIT_CLKS) @(negedge clk);
    check_level("tx stop bit", 1'b1, stx_pad_o);
    repeat (BIT_CLKS / 2 + 1) @(negedge clk);  // past the end of stop
    read_reg(LS, v);
    check_lsr("tx done lsr", expected_lsr(1'b0, 1'b0, 1'b0, 1'b1), v);
  endtask

  initial begin
    seed      = 32'h7af88276;
    wb_rst_i  = 1'b1;
    wb_addr_i = '0;
    wb_dat_i  = '0;
    wb_we_i   = 1'b0;
    wb_re_i   = 1'b0;
    srx_pad_i = 1'b1;   // line idle
    repeat (5) @(negedge clk);
    wb_rst_i  = 1'b0;
    test_reset_readback();
    test_loopback();
    test_external_rx();
    test_overrun();
    test_interrupts();
    test_tx_serial();
    $display("** PASS **");
    $finish;
  end

endmodule

`default_nettype wire
